// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -sv -f compile.f --top-module tb_fp_rename_unit -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
src/fp_rename_pkg.sv
src/fp_rename_table.sv
src/fp_free_list.sv
src/fp_rename_unit.sv
test/tb_fp_rename_unit.sv

// ==== src/fp_free_list.sv ====
/* Circular list of free FP physical registers for the rename stage.
   Pops on rename, pushes freed registers on commit, restores the head on recovery. */
module fp_free_list (
    input  logic                                           clk_i,
    input  logic                                           rstn_i,
    input  logic                                           pop_i,
    output fp_rename_pkg::phreg_t                          free_reg_o,
    input  fp_rename_pkg::commit_t [fp_rename_pkg::NUM_COMMIT-1:0] commit_i,
    input  logic                                           ckpt_take_i,
    input  fp_rename_pkg::checkpoint_ptr                   ckpt_slot_i,
    input  fp_rename_pkg::recover_t                        recover_i,
    output logic                                           empty_o
);
    import fp_rename_pkg::*;

    phreg_t    fifo_q [NUM_FREE];
    free_ptr_t saved_head_q [NUM_CHECKPOINTS];

    free_ptr_t head_q, head_d, head_pop;
    free_ptr_t commit_head_q;                        // Head as seen by retired code
    free_ptr_t tail_q;
    free_ptr_t push_cnt;
    free_ptr_t push_ptr [NUM_COMMIT];
    logic [NUM_COMMIT-1:0] push_en;

    assign free_reg_o = fifo_q[head_q[FREE_IDX_W-1:0]];
    assign empty_o    = (head_q == tail_q);
    assign head_pop   = head_q + free_ptr_t'(pop_i);

    // Pack the freed registers of this cycle's commits at the tail
    always_comb begin
        push_cnt = '0;
        for (int c = 0; c < NUM_COMMIT; c++) begin
            push_en[c]  = commit_i[c].valid & commit_i[c].write_dst & ~recover_i.recover_commit;
            push_ptr[c] = tail_q + push_cnt;
            push_cnt    = push_cnt + free_ptr_t'(push_en[c]);
        end
    end

    always_comb begin
        if (recover_i.recover_commit) begin
            head_d = commit_head_q;
        end else if (recover_i.do_recover) begin
            head_d = saved_head_q[recover_i.recover_checkpoint];
        end else begin
            head_d = head_pop;
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            head_q        <= '0;
            commit_head_q <= '0;
            tail_q        <= free_ptr_t'(NUM_FREE);  // Full, wrap bit set
            for (int k = 0; k < NUM_CHECKPOINTS; k++) begin
                saved_head_q[k] <= '0;
            end
        end else begin
            head_q        <= head_d;
            commit_head_q <= commit_head_q + push_cnt;
            tail_q        <= tail_q + push_cnt;
            if (ckpt_take_i) begin
                // Includes the pop of the instruction taking the checkpoint
                saved_head_q[ckpt_slot_i] <= head_pop;
            end
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_FREE; i++) begin
                fifo_q[i] <= phreg_t'(NUM_ISA_REGISTERS + i);
            end
        end else begin
            for (int c = 0; c < NUM_COMMIT; c++) begin
                if (push_en[c]) begin
                    fifo_q[push_ptr[c][FREE_IDX_W-1:0]] <= commit_i[c].old_dst;
                end
            end
        end
    end

endmodule

// ==== src/fp_rename_pkg.sv ====
/* Sizes, index types and packed structs shared by the FP rename stage.
   Imported by every module of the stage and by its testbench. */
package fp_rename_pkg;

    localparam int NUM_ISA_REGISTERS  = 32;   // Architectural FP registers
    localparam int NUM_PHYS_REGISTERS = 64;   // Physical FP registers
    localparam int NUM_CHECKPOINTS    = 4;    // Map versions
    localparam int NUM_FP_WB          = 2;    // Writeback ports
    localparam int NUM_COMMIT         = 2;    // Commits per cycle
    localparam int NUM_FREE           = NUM_PHYS_REGISTERS - NUM_ISA_REGISTERS;

    localparam int REG_W      = $clog2(NUM_ISA_REGISTERS);
    localparam int PHREG_W    = $clog2(NUM_PHYS_REGISTERS);
    localparam int CKPT_W     = $clog2(NUM_CHECKPOINTS);
    localparam int FREE_IDX_W = $clog2(NUM_FREE);

    typedef logic [REG_W-1:0]      reg_t;
    typedef logic [PHREG_W-1:0]    phreg_t;
    typedef logic [CKPT_W-1:0]     checkpoint_ptr;
    typedef logic [CKPT_W:0]       ckpt_cnt_t;     // One bit wider than a label
    typedef logic [FREE_IDX_W:0]   free_ptr_t;     // Top bit is the wrap bit

    typedef struct packed {
        reg_t src1, src2, src3;
        logic use_fs1, use_fs2, use_fs3;
        reg_t dst;
        logic write_dst;
        logic do_checkpoint;
    } rename_req_t;

    typedef struct packed {
        logic   valid;
        reg_t   vaddr;
        phreg_t paddr;
    } wb_t;

    typedef struct packed {
        logic   valid;
        logic   write_dst;
        reg_t   dst;
        phreg_t new_dst;
        phreg_t old_dst;                            // Register handed back to the free list
    } commit_t;

    typedef struct packed {
        phreg_t        src1, src2, src3;
        logic          rdy1, rdy2, rdy3;
        phreg_t        old_dst;
        phreg_t        new_dst;
        checkpoint_ptr checkpoint;
    } rename_rsp_t;

    typedef struct packed {
        logic          do_recover;
        checkpoint_ptr recover_checkpoint;
        logic          recover_commit;
        logic          delete_checkpoint;
    } recover_t;

endpackage

// ==== src/fp_rename_table.sv ====
/* FP map and ready tables with one copy per checkpoint version, plus the commit table.
   Looks up sources and old destination, takes and restores checkpoints. */
module fp_rename_table (
    input  logic                                           clk_i,
    input  logic                                           rstn_i,
    input  fp_rename_pkg::rename_req_t                     req_i,
    input  fp_rename_pkg::phreg_t                          new_dst_i,
    input  fp_rename_pkg::wb_t [fp_rename_pkg::NUM_FP_WB-1:0]      wb_i,
    input  fp_rename_pkg::commit_t [fp_rename_pkg::NUM_COMMIT-1:0] commit_i,
    input  fp_rename_pkg::recover_t                        recover_i,
    output fp_rename_pkg::rename_rsp_t                     src_o,
    output logic                                           ckpt_take_o,
    output fp_rename_pkg::checkpoint_ptr                   ckpt_slot_o,
    output logic                                           out_of_checkpoints_o
);
    import fp_rename_pkg::*;

    phreg_t map_q [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    phreg_t map_d [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    logic   rdy_q [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    logic   rdy_d [NUM_CHECKPOINTS][NUM_ISA_REGISTERS];
    phreg_t commit_q [NUM_ISA_REGISTERS];
    phreg_t commit_d [NUM_ISA_REGISTERS];

    checkpoint_ptr head_q, head_d, head_nxt;
    checkpoint_ptr tail_q, tail_d;
    ckpt_cnt_t     num_q, num_d;

    logic read_enable;
    logic write_enable;
    logic checkpoint_enable;

    // True when a writeback in this cycle produces the current mapping of src
    function automatic logic wb_hit(input reg_t src);
        logic hit;
        hit = 1'b0;
        for (int w = 0; w < NUM_FP_WB; w++) begin
            hit |= wb_i[w].valid & (wb_i[w].vaddr == src) &
                   (map_q[head_q][src] == wb_i[w].paddr);
        end
        return hit;
    endfunction

    assign read_enable       = ~recover_i.do_recover & ~recover_i.recover_commit;
    assign write_enable      = req_i.write_dst & read_enable;
    assign checkpoint_enable = req_i.do_checkpoint & read_enable &
                               (num_q < ckpt_cnt_t'(NUM_CHECKPOINTS - 1));
    assign head_nxt          = head_q + checkpoint_ptr'(1);

    assign ckpt_take_o          = checkpoint_enable;
    assign ckpt_slot_o          = head_q;            // Frozen version, the label of the branch
    assign out_of_checkpoints_o = (num_q == ckpt_cnt_t'(NUM_CHECKPOINTS - 1));

    always_comb begin
        map_d    = map_q;
        rdy_d    = rdy_q;
        commit_d = commit_q;
        head_d   = head_q;
        tail_d   = tail_q;
        num_d    = num_q;

        // Writebacks mark every version that still maps vaddr to paddr
        for (int w = 0; w < NUM_FP_WB; w++) begin
            if (wb_i[w].valid && !recover_i.recover_commit) begin
                for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                    if (map_q[v][wb_i[w].vaddr] == wb_i[w].paddr) begin
                        rdy_d[v][wb_i[w].vaddr] = 1'b1;
                    end
                end
            end
        end

        // Later port overwrites earlier one on the same register
        for (int c = 0; c < NUM_COMMIT; c++) begin
            if (commit_i[c].valid && commit_i[c].write_dst && !recover_i.recover_commit) begin
                commit_d[commit_i[c].dst] = commit_i[c].new_dst;
            end
        end

        if (recover_i.recover_commit) begin
            // Exception: architectural state becomes version 0
            map_d[0] = commit_q;
            for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                rdy_d[0][r] = 1'b1;
            end
            head_d = '0;
            tail_d = '0;
            num_d  = '0;
        end else if (recover_i.do_recover) begin
            tail_d = tail_q + checkpoint_ptr'(recover_i.delete_checkpoint);
            head_d = recover_i.recover_checkpoint;
            num_d  = ckpt_cnt_t'(checkpoint_ptr'(recover_i.recover_checkpoint - tail_d));
        end else begin
            tail_d = tail_q + checkpoint_ptr'(recover_i.delete_checkpoint);
            num_d  = num_q + ckpt_cnt_t'(checkpoint_enable) -
                     ckpt_cnt_t'(recover_i.delete_checkpoint);

            // Copy first so the new version sees this cycle's writebacks
            if (checkpoint_enable) begin
                map_d[head_nxt] = map_d[head_q];
                rdy_d[head_nxt] = rdy_d[head_q];
                head_d          = head_nxt;
            end

            // Rename write lands in the current and, if taken, the new version
            if (write_enable) begin
                map_d[head_q][req_i.dst] = new_dst_i;
                rdy_d[head_q][req_i.dst] = 1'b0;
                if (checkpoint_enable) begin
                    map_d[head_nxt][req_i.dst] = new_dst_i;
                    rdy_d[head_nxt][req_i.dst] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int v = 0; v < NUM_CHECKPOINTS; v++) begin
                for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                    map_q[v][r] <= phreg_t'(r);      // Identity mapping
                    rdy_q[v][r] <= 1'b1;
                end
            end
            for (int r = 0; r < NUM_ISA_REGISTERS; r++) begin
                commit_q[r] <= phreg_t'(r);
            end
            head_q <= '0;
            tail_q <= '0;
            num_q  <= '0;
        end else begin
            map_q    <= map_d;
            rdy_q    <= rdy_d;
            commit_q <= commit_d;
            head_q   <= head_d;
            tail_q   <= tail_d;
            num_q    <= num_d;
        end
    end

    // Lookup is read from the state before this edge's update
    always_ff @(posedge clk_i) begin
        if (read_enable) begin
            src_o.src1       <= map_q[head_q][req_i.src1];
            src_o.rdy1       <= rdy_q[head_q][req_i.src1] | wb_hit(req_i.src1) | ~req_i.use_fs1;
            src_o.src2       <= map_q[head_q][req_i.src2];
            src_o.rdy2       <= rdy_q[head_q][req_i.src2] | wb_hit(req_i.src2) | ~req_i.use_fs2;
            src_o.src3       <= map_q[head_q][req_i.src3];
            src_o.rdy3       <= rdy_q[head_q][req_i.src3] | wb_hit(req_i.src3) | ~req_i.use_fs3;
            src_o.old_dst    <= map_q[head_q][req_i.dst];
            src_o.checkpoint <= head_q;
        end
        src_o.new_dst <= '0;                         // Filled from the free list at the top
    end

endmodule

// ==== src/fp_rename_unit.sv ====
/* Top of the FP rename stage, joining the map table and the free list.
   Renames one instruction per cycle with the result one cycle later. */
module fp_rename_unit (
    input  logic                                           clk_i,
    input  logic                                           rstn_i,
    input  fp_rename_pkg::rename_req_t                     req_i,
    input  fp_rename_pkg::wb_t [fp_rename_pkg::NUM_FP_WB-1:0]      wb_i,
    input  fp_rename_pkg::commit_t [fp_rename_pkg::NUM_COMMIT-1:0] commit_i,
    input  fp_rename_pkg::recover_t                        recover_i,
    output fp_rename_pkg::rename_rsp_t                     rsp_o,
    output logic                                           rsp_valid_o,
    output logic                                           out_of_checkpoints_o,
    output logic                                           free_empty_o
);
    import fp_rename_pkg::*;

    rename_rsp_t   lookup;
    phreg_t        free_reg;
    phreg_t        new_dst_q;
    checkpoint_ptr ckpt_slot;
    logic          ckpt_take;
    logic          recovering;
    logic          pop;

    assign recovering = recover_i.do_recover | recover_i.recover_commit;
    assign pop        = req_i.write_dst & ~recovering;   // No rename while recovering

    fp_rename_table u_table (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .req_i                (req_i),
        .new_dst_i            (free_reg),
        .wb_i                 (wb_i),
        .commit_i             (commit_i),
        .recover_i            (recover_i),
        .src_o                (lookup),
        .ckpt_take_o          (ckpt_take),
        .ckpt_slot_o          (ckpt_slot),
        .out_of_checkpoints_o (out_of_checkpoints_o)
    );

    fp_free_list u_free_list (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .pop_i       (pop),
        .free_reg_o  (free_reg),
        .commit_i    (commit_i),
        .ckpt_take_i (ckpt_take),
        .ckpt_slot_i (ckpt_slot),
        .recover_i   (recover_i),
        .empty_o     (free_empty_o)
    );

    always_ff @(posedge clk_i) begin
        if (!recovering) begin
            new_dst_q <= free_reg;                      // Aligned with the table lookup
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= ~recovering;
        end
    end

    always_comb begin
        rsp_o         = lookup;
        rsp_o.new_dst = new_dst_q;
    end

endmodule

// ==== test/tb_fp_rename_unit.sv ====
/* Testbench for the FP rename stage, driving a table of stimulus rows on the falling edge
   and checking each registered response one cycle later. */
module tb_fp_rename_unit;
    import fp_rename_pkg::*;

    typedef struct packed {
        rename_req_t                  req;
        wb_t [NUM_FP_WB-1:0]          wb;
        commit_t [NUM_COMMIT-1:0]     commit;
        recover_t                     rec;
        rename_rsp_t                  exp;
        logic [8:0]                   mask;       // src1 rdy1 src2 rdy2 src3 rdy3 old new ckpt
        logic                         exp_valid;
        logic                         exp_ooc;
    } row_t;

    logic                        clk;
    logic                        rstn;
    rename_req_t                 req;
    wb_t [NUM_FP_WB-1:0]         wb;
    commit_t [NUM_COMMIT-1:0]    commit;
    recover_t                    recover;
    rename_rsp_t                 rsp;
    logic                        rsp_valid;
    logic                        ooc;
    logic                        free_empty;

    row_t  rows [$];
    string row_names [$];
    row_t  cur;
    string cur_name;

    fp_rename_unit dut_i (
        .clk_i                (clk),
        .rstn_i               (rstn),
        .req_i                (req),
        .wb_i                 (wb),
        .commit_i             (commit),
        .recover_i            (recover),
        .rsp_o                (rsp),
        .rsp_valid_o          (rsp_valid),
        .out_of_checkpoints_o (ooc),
        .free_empty_o         (free_empty)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic start_row(input string name, input int s1, input int s2, input int s3,
                             input logic [2:0] use_bits, input int dst, input int wr,
                             input int ck);
        cur                   = '0;
        cur.exp_valid         = 1'b1;
        cur.req.src1          = reg_t'(s1);
        cur.req.src2          = reg_t'(s2);
        cur.req.src3          = reg_t'(s3);
        cur.req.use_fs1       = use_bits[0];
        cur.req.use_fs2       = use_bits[1];
        cur.req.use_fs3       = use_bits[2];
        cur.req.dst           = reg_t'(dst);
        cur.req.write_dst     = (wr != 0);
        cur.req.do_checkpoint = (ck != 0);
        cur_name              = name;
    endtask

    task automatic add_row();
        rows.push_back(cur);
        row_names.push_back(cur_name);
    endtask

    task automatic set_wb(input int port, input int vaddr, input int paddr);
        cur.wb[port].valid = 1'b1;
        cur.wb[port].vaddr = reg_t'(vaddr);
        cur.wb[port].paddr = phreg_t'(paddr);
    endtask

    task automatic set_commit(input int port, input int dst, input int new_p, input int old_p);
        cur.commit[port].valid     = 1'b1;
        cur.commit[port].write_dst = 1'b1;
        cur.commit[port].dst       = reg_t'(dst);
        cur.commit[port].new_dst   = phreg_t'(new_p);
        cur.commit[port].old_dst   = phreg_t'(old_p);
    endtask

    task automatic expect_src(input int idx, input int p, input int rdy);
        case (idx)
            1: begin
                cur.exp.src1  = phreg_t'(p);
                cur.exp.rdy1  = (rdy != 0);
                cur.mask[1:0] = 2'b11;
            end
            2: begin
                cur.exp.src2  = phreg_t'(p);
                cur.exp.rdy2  = (rdy != 0);
                cur.mask[3:2] = 2'b11;
            end
            default: begin
                cur.exp.src3  = phreg_t'(p);
                cur.exp.rdy3  = (rdy != 0);
                cur.mask[5:4] = 2'b11;
            end
        endcase
    endtask

    task automatic expect_dst(input int old_p, input int new_p);
        cur.exp.old_dst = phreg_t'(old_p);
        cur.exp.new_dst = phreg_t'(new_p);
        cur.mask[7:6]   = 2'b11;
    endtask

    task automatic expect_ckpt(input int ck);
        cur.exp.checkpoint = checkpoint_ptr'(ck);
        cur.mask[8]        = 1'b1;
    endtask

    task automatic build_table();
        int s1;
        int s2;
        int s3;
        // Branch checkpoint first, so version 0 and its saved free head both hold the reset state
        start_row("ckpt_branch", 1, 2, 3, 3'b111, 0, 0, 1);
        expect_src(1, 1, 1);
        expect_src(2, 2, 1);
        expect_src(3, 3, 1);
        expect_ckpt(0);
        add_row();
        start_row("spec_first", 6, 0, 0, 3'b001, 6, 1, 0);
        expect_src(1, 6, 1);
        expect_dst(6, 32);
        expect_ckpt(1);
        add_row();
        start_row("spec_second", 6, 0, 0, 3'b001, 7, 1, 0);
        expect_src(1, 32, 0);
        expect_dst(7, 33);
        expect_ckpt(1);
        add_row();
        start_row("recover_branch", 0, 0, 0, 3'b000, 0, 0, 0);
        cur.rec.do_recover         = 1'b1;
        cur.rec.recover_checkpoint = '0;
        cur.exp_valid              = 1'b0;
        add_row();
        start_row("restored_map", 6, 7, 0, 3'b011, 6, 1, 0);
        expect_src(1, 6, 1);
        expect_src(2, 7, 1);
        expect_dst(6, 32);
        expect_ckpt(0);
        add_row();
        start_row("next_dst", 1, 0, 0, 3'b001, 4, 1, 0);
        expect_src(1, 1, 1);
        expect_dst(4, 33);
        add_row();
        start_row("rename_twice", 4, 0, 0, 3'b001, 4, 1, 0);
        expect_src(1, 33, 0);
        expect_dst(33, 34);
        add_row();
        // Stale paddr leaves the source busy, unused source reads ready
        start_row("wb_stale", 4, 6, 0, 3'b001, 0, 0, 0);
        set_wb(0, 4, 33);
        expect_src(1, 34, 0);
        expect_src(2, 32, 1);
        add_row();
        start_row("wb_forward", 6, 4, 0, 3'b011, 0, 0, 0);
        set_wb(1, 6, 32);
        expect_src(1, 32, 1);
        expect_src(2, 34, 0);
        add_row();
        start_row("wb_ready", 6, 4, 0, 3'b011, 0, 0, 0);
        set_wb(0, 4, 34);
        expect_src(1, 32, 1);
        expect_src(2, 34, 1);
        add_row();
        // Each branch renames too, so every saved free head differs
        start_row("ckpt_one", 4, 0, 0, 3'b001, 8, 1, 1);
        expect_src(1, 34, 1);
        expect_dst(8, 35);
        expect_ckpt(0);
        add_row();
        start_row("ckpt_two", 8, 0, 0, 3'b001, 9, 1, 1);
        expect_src(1, 35, 0);
        expect_dst(9, 36);
        expect_ckpt(1);
        add_row();
        start_row("ckpt_three", 0, 0, 0, 3'b000, 9, 1, 1);
        expect_dst(36, 37);
        expect_ckpt(2);
        cur.exp_ooc = 1'b1;
        add_row();
        start_row("ckpt_ignored", 0, 0, 0, 3'b000, 0, 0, 1);
        expect_ckpt(3);
        cur.exp_ooc = 1'b1;
        add_row();
        start_row("ckpt_delete", 6, 0, 0, 3'b001, 0, 0, 0);
        cur.rec.delete_checkpoint = 1'b1;
        expect_src(1, 32, 1);
        expect_ckpt(3);
        add_row();
        // Back to the second branch, dropping the rename made under the third
        start_row("recover_ckpt_two", 0, 0, 0, 3'b000, 0, 0, 0);
        cur.rec.do_recover         = 1'b1;
        cur.rec.recover_checkpoint = checkpoint_ptr'(1);
        cur.exp_valid              = 1'b0;
        add_row();
        start_row("restored_ckpt", 8, 9, 0, 3'b011, 10, 1, 0);
        expect_src(1, 35, 0);
        expect_src(2, 36, 0);
        expect_dst(10, 37);
        expect_ckpt(1);
        add_row();
        start_row("commit_pair", 0, 0, 0, 3'b000, 0, 0, 0);
        set_commit(0, 6, 32, 6);
        set_commit(1, 4, 33, 4);
        add_row();
        start_row("commit_same_dst", 0, 0, 0, 3'b000, 0, 0, 0);
        set_commit(0, 5, 36, 5);
        set_commit(1, 5, 37, 36);
        add_row();
        start_row("recover_commit", 0, 0, 0, 3'b000, 0, 0, 0);
        cur.rec.recover_commit = 1'b1;
        cur.exp_valid          = 1'b0;
        add_row();
        // Free head returns to the committed head, four entries past reset
        start_row("commit_map", 4, 5, 6, 3'b111, 7, 1, 0);
        expect_src(1, 33, 1);
        expect_src(2, 37, 1);
        expect_src(3, 32, 1);
        expect_dst(7, 36);
        expect_ckpt(0);
        add_row();
        for (int k = 0; k < 4; k++) begin
            s1 = 16 + int'($urandom % 16);            // Registers never renamed above
            s2 = 16 + int'($urandom % 16);
            s3 = 16 + int'($urandom % 16);
            start_row($sformatf("filler_%0d", k), s1, s2, s3, 3'b111, 0, 0, 0);
            expect_src(1, s1, 1);
            expect_src(2, s2, 1);
            expect_src(3, s3, 1);
            expect_ckpt(0);
            add_row();
        end
    endtask

    task automatic apply_row(input int i);
        req     = rows[i].req;
        wb      = rows[i].wb;
        commit  = rows[i].commit;
        recover = rows[i].rec;
    endtask

    task automatic check_value(input string row, input string field, input int exp, input int act);
        assert (exp == act) else begin
            $display("Error: row %s, %s expected %0d, actual %0d", row, field, exp, act);
            $display("Verification failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic check_row(input int i);
        row_t  r;
        string n;
        r = rows[i];
        n = row_names[i];
        check_value(n, "rsp_valid", int'(r.exp_valid), int'(rsp_valid));
        check_value(n, "out_of_checkpoints", int'(r.exp_ooc), int'(ooc));
        // At most a handful of registers are out at once, far below the list depth
        check_value(n, "free_empty", 0, int'(free_empty));
        if (r.mask[0]) check_value(n, "src1", int'(r.exp.src1), int'(rsp.src1));
        if (r.mask[1]) check_value(n, "rdy1", int'(r.exp.rdy1), int'(rsp.rdy1));
        if (r.mask[2]) check_value(n, "src2", int'(r.exp.src2), int'(rsp.src2));
        if (r.mask[3]) check_value(n, "rdy2", int'(r.exp.rdy2), int'(rsp.rdy2));
        if (r.mask[4]) check_value(n, "src3", int'(r.exp.src3), int'(rsp.src3));
        if (r.mask[5]) check_value(n, "rdy3", int'(r.exp.rdy3), int'(rsp.rdy3));
        if (r.mask[6]) check_value(n, "old_dst", int'(r.exp.old_dst), int'(rsp.old_dst));
        if (r.mask[7]) check_value(n, "new_dst", int'(r.exp.new_dst), int'(rsp.new_dst));
        if (r.mask[8]) check_value(n, "checkpoint", int'(r.exp.checkpoint), int'(rsp.checkpoint));
    endtask

    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 2 * rows.size() + 20) begin
                $display("Timeout: the stimulus table did not finish within %0d cycles", cycles - 1);
                $display("Verification failed");
                $fatal(1, "Run stopped by timeout");
            end
        end
    end

    initial begin
        rstn    = 1'b0;
        req     = '0;
        wb      = '0;
        commit  = '0;
        recover = '0;
        void'($urandom(32'hbbe7));
        build_table();
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        check_value("reset", "rsp_valid", 0, int'(rsp_valid));
        check_value("reset", "out_of_checkpoints", 0, int'(ooc));
        check_value("reset", "free_empty", 0, int'(free_empty));
        for (int i = 0; i <= rows.size(); i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_row(i - 1);                   // Response of the previous row
            end
            if (i < rows.size()) begin
                apply_row(i);
            end else begin
                req     = '0;
                wb      = '0;
                commit  = '0;
                recover = '0;
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule
